// File: rtl/core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Datapath and register file size
`define XLEN 32
`define NUM_REGS 32

// First fetch address after reset
`define RESET_PC 32'h1c000000

// 3R-type opcodes, instr[31:15]
`define OPC_ADD_W 17'h00020
`define OPC_SUB_W 17'h00022
// 2RI12-type opcode, instr[31:22]
`define OPC_ADDI_W 10'h00a
// 1RI20-type opcode, instr[31:25]
`define OPC_LU12I_W 7'h0a
// 2RI16 branch opcodes, instr[31:26]
`define OPC_BEQ 6'h16
`define OPC_BNE 6'h17

`endif

// File: rtl/core_pkg.sv
`include "core_cfg.svh"

package core_pkg;

    // Register data word
    typedef logic [`XLEN-1:0] word_t;

    // Byte address on the fetch bus
    typedef logic [`XLEN-1:0] addr_t;

    // Raw instruction as returned by memory
    typedef logic [31:0] instr_t;

    // Architectural register number
    typedef logic [$clog2(`NUM_REGS)-1:0] reg_idx_t;

    // Operation carried from decode to execute
    // ADDI.W and LU12I.W are folded into EXEC_ADD with an immediate operand
    typedef enum logic [2:0] {
        EXEC_NOP,
        EXEC_ADD,
        EXEC_SUB,
        EXEC_BEQ,
        EXEC_BNE
    } exec_op_e;

endpackage

// File: rtl/pipe_if.sv
`timescale 1ns/10ps

// Decode to execute pipeline register contents
interface dec_ex_if import core_pkg::*; ();

    logic     valid;
    addr_t    pc;
    exec_op_e op;
    reg_idx_t rd;
    logic     wen;
    word_t    src_a;
    word_t    src_b;
    addr_t    target;

    modport decode (
        output valid,
        output pc,
        output op,
        output rd,
        output wen,
        output src_a,
        output src_b,
        output target
    );

    modport execute (
        input valid,
        input pc,
        input op,
        input rd,
        input wen,
        input src_a,
        input src_b,
        input target
    );

endinterface

// Execute to writeback pipeline register contents
interface ex_wb_if import core_pkg::*; ();

    logic     valid;
    addr_t    pc;
    logic     wen;
    reg_idx_t rd;
    word_t    wdata;

    modport execute (output valid, output pc, output wen, output rd, output wdata);

    modport writeback (input valid, input pc, input wen, input rd, input wdata);

    // Bypass path back into decode
    modport forward (input valid, input wen, input rd, input wdata);

endinterface

// File: rtl/fetch_stage.sv
`timescale 1ns/10ps
`include "core_cfg.svh"

module fetch_stage import core_pkg::*; (
    input  logic   clk,
    input  logic   rst_n_i,
    output addr_t  araddr_o,
    output logic   arvalid_o,
    input  logic   arready_i,
    input  word_t  rdata_i,
    input  logic   rvalid_i,
    output logic   rready_o,
    input  logic   redirect_valid_i,
    input  addr_t  redirect_pc_i,
    output logic   f_valid_o,
    output addr_t  f_pc_o,
    output instr_t f_instr_o
);

    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        DATA,
        DRAIN
    } fetch_state_e;

    fetch_state_e state_q;
    fetch_state_e state_d;
    addr_t        pc_q;
    addr_t        addr_q;
    logic         kill_q;
    logic         f_valid_q;
    addr_t        f_pc_q;
    instr_t       f_instr_q;
    logic         ar_fire;
    logic         r_fire;

    assign arvalid_o = (state_q == ADDR);
    assign rready_o  = (state_q == DATA) || (state_q == DRAIN);
    assign araddr_o  = addr_q;
    assign ar_fire   = arvalid_o && arready_i;
    assign r_fire    = rready_o && rvalid_i;

    assign f_valid_o = f_valid_q;
    assign f_pc_o    = f_pc_q;
    assign f_instr_o = f_instr_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            // IDLE is also the cycle the buffer is handed to decode
            IDLE: state_d = ADDR;
            ADDR: begin
                if (ar_fire) begin
                    state_d = (kill_q || redirect_valid_i) ? DRAIN : DATA;
                end
            end
            DATA: begin
                if (r_fire) begin
                    state_d = IDLE;
                end else if (redirect_valid_i) begin
                    state_d = DRAIN;
                end
            end
            DRAIN: begin
                if (r_fire) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q   <= IDLE;
            pc_q      <= `RESET_PC;
            kill_q    <= 1'b0;
            f_valid_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (redirect_valid_i) begin
                pc_q <= redirect_pc_i;
            end else if (state_q == DATA && r_fire) begin
                pc_q <= addr_q + 32'd4;
            end
            // Address already on the bus cannot be withdrawn, remember to drop it
            if (ar_fire) begin
                kill_q <= 1'b0;
            end else if (state_q == ADDR && redirect_valid_i) begin
                kill_q <= 1'b1;
            end
            f_valid_q <= (state_q == DATA) && r_fire && !redirect_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE) begin
            addr_q <= redirect_valid_i ? redirect_pc_i : pc_q;
        end
        if (state_q == DATA && r_fire) begin
            f_pc_q    <= addr_q;
            f_instr_q <= rdata_i;
        end
    end

    a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        arvalid_o && !arready_i |=> arvalid_o && $stable(araddr_o));

endmodule

// File: rtl/decode_stage.sv
`timescale 1ns/10ps
`include "core_cfg.svh"

module decode_stage import core_pkg::*; (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            f_valid_i,
    input  addr_t           f_pc_i,
    input  instr_t          f_instr_i,
    output reg_idx_t        rf_raddr_a_o,
    output reg_idx_t        rf_raddr_b_o,
    input  word_t           rf_rdata_a_i,
    input  word_t           rf_rdata_b_i,
    input  logic            ex_fwd_wen_i,
    input  reg_idx_t        ex_fwd_rd_i,
    input  word_t           ex_fwd_data_i,
    ex_wb_if.forward        wb_fwd,
    input  logic            redirect_valid_i,
    dec_ex_if.decode        dec_ex
);

    reg_idx_t rd;
    reg_idx_t rj;
    reg_idx_t rk;
    logic     is_add;
    logic     is_sub;
    logic     is_addi;
    logic     is_lu12i;
    logic     is_beq;
    logic     is_bne;
    word_t    imm_si12;
    word_t    imm_si20;
    addr_t    br_target;
    logic     wb_fwd_en;
    word_t    opnd_a;
    word_t    opnd_b;
    exec_op_e op_d;
    logic     wen_d;
    word_t    src_a_d;
    word_t    src_b_d;

    assign rd = f_instr_i[4:0];
    assign rj = f_instr_i[9:5];
    assign rk = f_instr_i[14:10];

    assign is_add   = (f_instr_i[31:15] == `OPC_ADD_W);
    assign is_sub   = (f_instr_i[31:15] == `OPC_SUB_W);
    assign is_addi  = (f_instr_i[31:22] == `OPC_ADDI_W);
    assign is_lu12i = (f_instr_i[31:25] == `OPC_LU12I_W);
    assign is_beq   = (f_instr_i[31:26] == `OPC_BEQ);
    assign is_bne   = (f_instr_i[31:26] == `OPC_BNE);

    assign imm_si12  = {{20{f_instr_i[21]}}, f_instr_i[21:10]};
    assign imm_si20  = {f_instr_i[24:5], 12'b0};
    // offs16 is in words
    assign br_target = f_pc_i + {{14{f_instr_i[25]}}, f_instr_i[25:10], 2'b00};

    // Branches compare rj against rd, so port b reads rd for them
    assign rf_raddr_a_o = rj;
    assign rf_raddr_b_o = (is_beq || is_bne) ? rd : rk;

    assign wb_fwd_en = wb_fwd.valid && wb_fwd.wen;

    // Youngest producer wins, r0 never matches since its wen is cleared
    function automatic word_t bypass(input reg_idx_t idx, input word_t rf_val);
        word_t val;
        if (ex_fwd_wen_i && ex_fwd_rd_i == idx) begin
            val = ex_fwd_data_i;
        end else if (wb_fwd_en && wb_fwd.rd == idx) begin
            val = wb_fwd.wdata;
        end else begin
            val = rf_val;
        end
        return val;
    endfunction

    assign opnd_a = bypass(rf_raddr_a_o, rf_rdata_a_i);
    assign opnd_b = bypass(rf_raddr_b_o, rf_rdata_b_i);

    always_comb begin
        op_d    = EXEC_NOP;
        wen_d   = 1'b0;
        src_a_d = opnd_a;
        src_b_d = opnd_b;
        if (is_add || is_sub) begin
            op_d  = is_sub ? EXEC_SUB : EXEC_ADD;
            wen_d = 1'b1;
        end else if (is_addi) begin
            op_d    = EXEC_ADD;
            wen_d   = 1'b1;
            src_b_d = imm_si12;
        end else if (is_lu12i) begin
            op_d    = EXEC_ADD;
            wen_d   = 1'b1;
            src_a_d = '0;
            src_b_d = imm_si20;
        end else if (is_beq || is_bne) begin
            op_d = is_beq ? EXEC_BEQ : EXEC_BNE;
        end
        if (rd == '0) begin
            wen_d = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dec_ex.valid <= 1'b0;
        end else begin
            dec_ex.valid <= f_valid_i && !redirect_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        dec_ex.pc     <= f_pc_i;
        dec_ex.op     <= op_d;
        dec_ex.rd     <= rd;
        dec_ex.wen    <= wen_d;
        dec_ex.src_a  <= src_a_d;
        dec_ex.src_b  <= src_b_d;
        dec_ex.target <= br_target;
    end

endmodule

// File: rtl/regfile.sv
`timescale 1ns/10ps
`include "core_cfg.svh"

module regfile import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    input  reg_idx_t raddr_a_i,
    input  reg_idx_t raddr_b_i,
    output word_t    rdata_a_o,
    output word_t    rdata_b_o,
    input  logic     we_i,
    input  reg_idx_t waddr_i,
    input  word_t    wdata_i
);

    word_t regs [`NUM_REGS];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // r0 is constant zero
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

endmodule

// File: rtl/execute_stage.sv
`timescale 1ns/10ps

module execute_stage import core_pkg::*; (
    input  logic             clk,
    input  logic             rst_n_i,
    dec_ex_if.execute        dec_ex,
    output logic             ex_fwd_wen_o,
    output reg_idx_t         ex_fwd_rd_o,
    output word_t            ex_fwd_data_o,
    output logic             redirect_valid_o,
    output addr_t            redirect_pc_o,
    ex_wb_if.execute         ex_wb
);

    word_t result;
    logic  equal;
    logic  taken;

    always_comb begin
        case (dec_ex.op)
            EXEC_ADD: result = dec_ex.src_a + dec_ex.src_b;
            EXEC_SUB: result = dec_ex.src_a - dec_ex.src_b;
            // Branches and unsupported encodings produce no value
            default:  result = '0;
        endcase
    end

    assign equal = (dec_ex.src_a == dec_ex.src_b);
    assign taken = (dec_ex.op == EXEC_BEQ && equal) || (dec_ex.op == EXEC_BNE && !equal);

    assign redirect_valid_o = dec_ex.valid && taken;
    assign redirect_pc_o    = dec_ex.target;

    assign ex_fwd_wen_o  = dec_ex.valid && dec_ex.wen;
    assign ex_fwd_rd_o   = dec_ex.rd;
    assign ex_fwd_data_o = result;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_wb.valid <= 1'b0;
        end else begin
            ex_wb.valid <= dec_ex.valid;
        end
    end

    always_ff @(posedge clk) begin
        ex_wb.pc    <= dec_ex.pc;
        ex_wb.wen   <= dec_ex.wen;
        ex_wb.rd    <= dec_ex.rd;
        ex_wb.wdata <= result;
    end

    // The redirect squashes dec_ex, so no fall-through follows the branch into execute
    a_redirect_squash: assert property (@(posedge clk) disable iff (!rst_n_i)
        redirect_valid_o |=> !dec_ex.valid);

endmodule

// File: rtl/writeback_stage.sv
`timescale 1ns/10ps

module writeback_stage import core_pkg::*; (
    input  logic         clk,
    input  logic         rst_n_i,
    ex_wb_if.writeback   ex_wb,
    output logic         rf_we_o,
    output reg_idx_t     rf_waddr_o,
    output word_t        rf_wdata_o,
    output logic         dbg_wb_valid_o,
    output addr_t        dbg_wb_pc_o,
    output logic         dbg_wb_rf_wen_o,
    output reg_idx_t     dbg_wb_rf_wnum_o,
    output word_t        dbg_wb_rf_wdata_o
);

    assign rf_we_o    = ex_wb.valid && ex_wb.wen;
    assign rf_waddr_o = ex_wb.rd;
    assign rf_wdata_o = ex_wb.wdata;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dbg_wb_valid_o  <= 1'b0;
            dbg_wb_rf_wen_o <= 1'b0;
        end else begin
            dbg_wb_valid_o  <= ex_wb.valid;
            dbg_wb_rf_wen_o <= rf_we_o;
        end
    end

    // Commit port trails the register write by one cycle
    always_ff @(posedge clk) begin
        if (ex_wb.valid) begin
            dbg_wb_pc_o       <= ex_wb.pc;
            dbg_wb_rf_wnum_o  <= ex_wb.rd;
            dbg_wb_rf_wdata_o <= ex_wb.wdata;
        end
    end

    a_no_r0_write: assert property (@(posedge clk) disable iff (!rst_n_i)
        rf_we_o |-> rf_waddr_o != '0);

endmodule

// File: rtl/core_top.sv
`timescale 1ns/10ps

module core_top import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    output addr_t    araddr_o,
    output logic     arvalid_o,
    input  logic     arready_i,
    input  word_t    rdata_i,
    input  logic     rvalid_i,
    output logic     rready_o,
    output logic     dbg_wb_valid_o,
    output addr_t    dbg_wb_pc_o,
    output logic     dbg_wb_rf_wen_o,
    output reg_idx_t dbg_wb_rf_wnum_o,
    output word_t    dbg_wb_rf_wdata_o
);

    // Fetch buffer to decode
    logic     f_valid;
    addr_t    f_pc;
    instr_t   f_instr;

    // Register file ports
    reg_idx_t rf_raddr_a;
    reg_idx_t rf_raddr_b;
    word_t    rf_rdata_a;
    word_t    rf_rdata_b;
    logic     rf_we;
    reg_idx_t rf_waddr;
    word_t    rf_wdata;

    // Execute bypass and branch redirect
    logic     ex_fwd_wen;
    reg_idx_t ex_fwd_rd;
    word_t    ex_fwd_data;
    logic     redirect_valid;
    addr_t    redirect_pc;

    dec_ex_if u_dec_ex ();
    ex_wb_if  u_ex_wb ();

    fetch_stage u_fetch (
        .clk(clk), .rst_n_i(rst_n_i),
        .araddr_o(araddr_o), .arvalid_o(arvalid_o), .arready_i(arready_i),
        .rdata_i(rdata_i), .rvalid_i(rvalid_i), .rready_o(rready_o),
        .redirect_valid_i(redirect_valid), .redirect_pc_i(redirect_pc),
        .f_valid_o(f_valid), .f_pc_o(f_pc), .f_instr_o(f_instr)
    );

    decode_stage u_decode (
        .clk(clk), .rst_n_i(rst_n_i),
        .f_valid_i(f_valid), .f_pc_i(f_pc), .f_instr_i(f_instr),
        .rf_raddr_a_o(rf_raddr_a), .rf_raddr_b_o(rf_raddr_b),
        .rf_rdata_a_i(rf_rdata_a), .rf_rdata_b_i(rf_rdata_b),
        .ex_fwd_wen_i(ex_fwd_wen), .ex_fwd_rd_i(ex_fwd_rd), .ex_fwd_data_i(ex_fwd_data),
        .wb_fwd(u_ex_wb), .redirect_valid_i(redirect_valid), .dec_ex(u_dec_ex)
    );

    regfile u_regfile (
        .clk(clk), .rst_n_i(rst_n_i),
        .raddr_a_i(rf_raddr_a), .raddr_b_i(rf_raddr_b),
        .rdata_a_o(rf_rdata_a), .rdata_b_o(rf_rdata_b),
        .we_i(rf_we), .waddr_i(rf_waddr), .wdata_i(rf_wdata)
    );

    execute_stage u_execute (
        .clk(clk), .rst_n_i(rst_n_i), .dec_ex(u_dec_ex),
        .ex_fwd_wen_o(ex_fwd_wen), .ex_fwd_rd_o(ex_fwd_rd), .ex_fwd_data_o(ex_fwd_data),
        .redirect_valid_o(redirect_valid), .redirect_pc_o(redirect_pc), .ex_wb(u_ex_wb)
    );

    writeback_stage u_writeback (
        .clk(clk), .rst_n_i(rst_n_i), .ex_wb(u_ex_wb),
        .rf_we_o(rf_we), .rf_waddr_o(rf_waddr), .rf_wdata_o(rf_wdata),
        .dbg_wb_valid_o(dbg_wb_valid_o), .dbg_wb_pc_o(dbg_wb_pc_o),
        .dbg_wb_rf_wen_o(dbg_wb_rf_wen_o), .dbg_wb_rf_wnum_o(dbg_wb_rf_wnum_o),
        .dbg_wb_rf_wdata_o(dbg_wb_rf_wdata_o)
    );

endmodule

// File: dv/tb_model.sv
`timescale 1ns/10ps
`include "core_cfg.svh"

module tb_model import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    input  addr_t    rom_addr_i,
    output instr_t   rom_data_o,
    input  logic     commit_valid_i,
    input  addr_t    commit_pc_i,
    input  logic     commit_wen_i,
    input  reg_idx_t commit_wnum_i,
    input  word_t    commit_wdata_i,
    output logic     check_failed_o
);

    localparam int PROG_LEN = 32;
    // ADD.D, a valid encoding outside the subset
    localparam logic [16:0] OPC_ADD_D = 17'h00021;

    instr_t   rom [PROG_LEN];
    word_t    regs [`NUM_REGS];
    addr_t    pc_q;
    instr_t   cur_instr;
    word_t    rj_val;
    word_t    rk_val;
    word_t    rd_val;
    logic     taken;
    addr_t    next_pc;
    logic     exp_wen;
    reg_idx_t exp_wnum;
    word_t    exp_wdata;

    function automatic instr_t three_reg_word(input logic [16:0] opc, input int rd,
                                              input int rj, input int rk);
        return {opc, rk[4:0], rj[4:0], rd[4:0]};
    endfunction

    function automatic instr_t addi_word(input int rd, input int rj, input int si12);
        return {`OPC_ADDI_W, si12[11:0], rj[4:0], rd[4:0]};
    endfunction

    function automatic instr_t lu12i_word(input int rd, input int si20);
        return {`OPC_LU12I_W, si20[19:0], rd[4:0]};
    endfunction

    // Offset counted in instruction words
    function automatic instr_t branch_word(input logic [5:0] opc, input int rj,
                                           input int rd, input int offs);
        return {opc, offs[15:0], rj[4:0], rd[4:0]};
    endfunction

    // Outside the program the memory returns the inverted address
    function automatic instr_t fetch_word(input addr_t addr);
        int unsigned idx;
        idx = (addr - `RESET_PC) >> 2;
        if (addr >= `RESET_PC && idx < PROG_LEN) begin
            return rom[idx];
        end
        return ~addr;
    endfunction

    initial begin : load_program
        check_failed_o = 1'b0;
        rom[0]  = addi_word(1, 0, 5);
        rom[1]  = addi_word(2, 1, -3);
        rom[2]  = three_reg_word(`OPC_ADD_W, 3, 1, 2);
        rom[3]  = three_reg_word(`OPC_SUB_W, 4, 2, 3);
        rom[4]  = addi_word(5, 4, -2048);
        rom[5]  = lu12i_word(6, 'h12345);
        rom[6]  = addi_word(6, 6, 'h678);
        rom[7]  = lu12i_word(7, 'hfffff);
        // Writes to r0
        rom[8]  = three_reg_word(`OPC_ADD_W, 0, 1, 2);
        rom[9]  = addi_word(0, 0, 1);
        rom[10] = three_reg_word(OPC_ADD_D, 3, 2, 3);
        rom[11] = three_reg_word(`OPC_SUB_W, 8, 3, 1);
        rom[12] = branch_word(`OPC_BEQ, 8, 2, 2);
        rom[13] = addi_word(9, 0, 'h111);
        // Not taken
        rom[14] = branch_word(`OPC_BNE, 8, 2, 3);
        rom[15] = addi_word(9, 9, 1);
        rom[16] = branch_word(`OPC_BNE, 9, 0, 2);
        rom[17] = addi_word(10, 0, 'h7ff);
        rom[18] = three_reg_word(`OPC_ADD_W, 10, 9, 9);
        rom[19] = three_reg_word(`OPC_ADD_W, 10, 10, 10);
        // Two-pass backward loop
        rom[20] = three_reg_word(`OPC_SUB_W, 10, 10, 9);
        rom[21] = addi_word(11, 11, 1);
        rom[22] = branch_word(`OPC_BNE, 11, 8, -2);
        rom[23] = branch_word(`OPC_BEQ, 10, 8, 2);
        rom[24] = addi_word(12, 0, -1);
        rom[25] = lu12i_word(12, 'h80000);
        rom[26] = addi_word(12, 12, -1);
        rom[27] = three_reg_word(`OPC_SUB_W, 13, 0, 12);
        rom[28] = three_reg_word(`OPC_ADD_W, 13, 13, 12);
        rom[29] = branch_word(`OPC_BEQ, 13, 0, 2);
        rom[30] = addi_word(14, 0, 1);
        rom[31] = branch_word(`OPC_BEQ, 0, 0, 0);
    end

    always_comb begin
        rom_data_o = fetch_word(rom_addr_i);
    end

    // Expected effect of the instruction at the model PC
    always_comb begin
        cur_instr = fetch_word(pc_q);
        rj_val    = regs[cur_instr[9:5]];
        rk_val    = regs[cur_instr[14:10]];
        rd_val    = regs[cur_instr[4:0]];
        exp_wnum  = cur_instr[4:0];
        exp_wen   = 1'b0;
        exp_wdata = '0;
        taken     = 1'b0;
        next_pc   = pc_q + 32'd4;
        if (cur_instr[31:15] == `OPC_ADD_W) begin
            exp_wen   = 1'b1;
            exp_wdata = rj_val + rk_val;
        end else if (cur_instr[31:15] == `OPC_SUB_W) begin
            exp_wen   = 1'b1;
            exp_wdata = rj_val - rk_val;
        end else if (cur_instr[31:22] == `OPC_ADDI_W) begin
            exp_wen   = 1'b1;
            exp_wdata = rj_val + word_t'(int'($signed(cur_instr[21:10])));
        end else if (cur_instr[31:25] == `OPC_LU12I_W) begin
            exp_wen   = 1'b1;
            exp_wdata = {cur_instr[24:5], 12'h000};
        end else if (cur_instr[31:26] == `OPC_BEQ) begin
            taken = (rj_val == rd_val);
        end else if (cur_instr[31:26] == `OPC_BNE) begin
            taken = (rj_val != rd_val);
        end
        if (taken) begin
            next_pc = pc_q + addr_t'(int'($signed(cur_instr[25:10])) * 4);
        end
        // r0 ignores writes
        if (exp_wnum == '0) begin
            exp_wen = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= `RESET_PC;
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (commit_valid_i) begin
            pc_q <= next_pc;
            if (exp_wen) begin
                regs[exp_wnum] <= exp_wdata;
            end
        end
    end

    a_commit_pc: assert property (@(posedge clk) disable iff (!rst_n_i)
        commit_valid_i |-> commit_pc_i == pc_q)
        else begin
            $display("FAIL %0t: commit pc %h, expected %h", $time,
                $sampled(commit_pc_i), $sampled(pc_q));
            check_failed_o = 1'b1;
        end

    a_commit_wen: assert property (@(posedge clk) disable iff (!rst_n_i)
        commit_valid_i |-> commit_wen_i == exp_wen)
        else begin
            $display("FAIL %0t: commit wen %b at pc %h, expected %b", $time,
                $sampled(commit_wen_i), $sampled(pc_q), $sampled(exp_wen));
            check_failed_o = 1'b1;
        end

    a_commit_wnum: assert property (@(posedge clk) disable iff (!rst_n_i)
        commit_valid_i && exp_wen |-> commit_wnum_i == exp_wnum)
        else begin
            $display("FAIL %0t: commit wnum %0d at pc %h, expected %0d", $time,
                $sampled(commit_wnum_i), $sampled(pc_q), $sampled(exp_wnum));
            check_failed_o = 1'b1;
        end

    a_commit_wdata: assert property (@(posedge clk) disable iff (!rst_n_i)
        commit_valid_i && exp_wen |-> commit_wdata_i == exp_wdata)
        else begin
            $display("FAIL %0t: commit wdata %h at pc %h, expected %h", $time,
                $sampled(commit_wdata_i), $sampled(pc_q), $sampled(exp_wdata));
            check_failed_o = 1'b1;
        end

endmodule

// File: dv/tb_top.sv
`timescale 1ns/10ps
`include "core_cfg.svh"

module tb_top import core_pkg::*; ();

    localparam int    RESET_CYCLES   = 16;
    // 31 commits reach the self-loop, then two more laps of it
    localparam int    NUM_COMMITS    = 33;
    // Self-loop is the last program word
    localparam addr_t LOOP_PC        = `RESET_PC + 32'd124;
    // About 13 cycles per fetch at worst, some 45 fetches with squashed ones, 5x margin
    localparam int    TIMEOUT_CYCLES = 3000;

    logic     clk;
    logic     rst_n;
    addr_t    araddr;
    logic     arvalid;
    logic     arready;
    word_t    rdata;
    logic     rvalid;
    logic     rready;
    logic     dbg_wb_valid;
    addr_t    dbg_wb_pc;
    logic     dbg_wb_rf_wen;
    reg_idx_t dbg_wb_rf_wnum;
    word_t    dbg_wb_rf_wdata;
    addr_t    rom_addr;
    instr_t   rom_data;
    logic     model_failed;
    int       cycle_cnt;
    int       commit_cnt;
    logic     first_ar_done;
    logic     rd_pending;

    core_top DUT (
        .clk(clk), .rst_n_i(rst_n),
        .araddr_o(araddr), .arvalid_o(arvalid), .arready_i(arready),
        .rdata_i(rdata), .rvalid_i(rvalid), .rready_o(rready),
        .dbg_wb_valid_o(dbg_wb_valid), .dbg_wb_pc_o(dbg_wb_pc),
        .dbg_wb_rf_wen_o(dbg_wb_rf_wen), .dbg_wb_rf_wnum_o(dbg_wb_rf_wnum),
        .dbg_wb_rf_wdata_o(dbg_wb_rf_wdata)
    );

    tb_model u_model (
        .clk(clk), .rst_n_i(rst_n),
        .rom_addr_i(rom_addr), .rom_data_o(rom_data),
        .commit_valid_i(dbg_wb_valid), .commit_pc_i(dbg_wb_pc),
        .commit_wen_i(dbg_wb_rf_wen), .commit_wnum_i(dbg_wb_rf_wnum),
        .commit_wdata_i(dbg_wb_rf_wdata), .check_failed_o(model_failed)
    );

    always #4 clk = ~clk;

    task automatic abort_run();
        $display("Something failed");
        $fatal(1, "Stopping at the first error");
    endtask

    // One read: random hold-off before arready and before rvalid
    task automatic serve_read();
        int unsigned ar_wait;
        int unsigned r_wait;
        do begin
            @(negedge clk);
        end while (!arvalid);
        ar_wait = $urandom % 4;
        repeat (ar_wait) @(negedge clk);
        rom_addr = araddr;
        @(posedge clk);
        arready <= 1'b1;
        @(posedge clk);
        arready <= 1'b0;
        r_wait = $urandom % 4;
        repeat (r_wait) @(posedge clk);
        rvalid <= 1'b1;
        rdata  <= rom_data;
        @(posedge clk);
        rvalid <= 1'b0;
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (dbg_wb_valid) begin
            commit_cnt <= commit_cnt + 1;
        end
        if (arvalid && arready) begin
            first_ar_done <= 1'b1;
            rd_pending    <= 1'b1;
        end else if (rvalid && rready) begin
            rd_pending <= 1'b0;
        end
    end

    initial begin : run_control
        clk           = 1'b0;
        rst_n         = 1'b0;
        arready       = 1'b0;
        rvalid        = 1'b0;
        rdata         = '0;
        rom_addr      = `RESET_PC;
        cycle_cnt     = 0;
        commit_cnt    = 0;
        first_ar_done = 1'b0;
        rd_pending    = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        while (commit_cnt < NUM_COMMITS && cycle_cnt < TIMEOUT_CYCLES) begin
            @(negedge clk);
        end
        if (commit_cnt >= NUM_COMMITS) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("Run timed out after %0d cycles with %0d of %0d commits",
                cycle_cnt, commit_cnt, NUM_COMMITS);
            abort_run();
        end
    end

    initial begin : bus_responder
        void'($urandom(32'he529));
        wait (rst_n === 1'b1);
        forever begin
            serve_read();
        end
    end

    initial begin : model_monitor
        @(posedge model_failed);
        abort_run();
    end

    // Covers the reset cycles and the first cycle after release
    a_reset_quiet: assert property (@(posedge clk)
        cycle_cnt > 0 && !$past(rst_n) |-> !arvalid && !rready && !dbg_wb_valid)
        else begin
            $display("FAIL %0t: arvalid, rready or commit valid high around reset", $time);
            abort_run();
        end

    a_first_addr: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && arready && !first_ar_done |-> araddr == `RESET_PC)
        else begin
            $display("FAIL %0t: first fetch address %h, expected %h", $time,
                $sampled(araddr), `RESET_PC);
            abort_run();
        end

    a_ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else begin
            $display("FAIL %0t: read address dropped or changed while stalled", $time);
            abort_run();
        end

    // rready marks exactly the cycles with a read outstanding
    a_rready_pending: assert property (@(posedge clk) disable iff (!rst_n)
        rready == rd_pending)
        else begin
            $display("FAIL %0t: rready %b, read outstanding %b", $time,
                $sampled(rready), $sampled(rd_pending));
            abort_run();
        end

    a_last_commit: assert property (@(posedge clk) disable iff (!rst_n)
        dbg_wb_valid && commit_cnt == NUM_COMMITS - 1 |-> dbg_wb_pc == LOOP_PC)
        else begin
            $display("FAIL %0t: last commit pc %h, expected %h", $time,
                $sampled(dbg_wb_pc), LOOP_PC);
            abort_run();
        end

endmodule

// File: project.f
+incdir+rtl
rtl/core_pkg.sv
rtl/pipe_if.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/regfile.sv
rtl/execute_stage.sv
rtl/writeback_stage.sv
rtl/core_top.sv
dv/tb_model.sv
dv/tb_top.sv

// File: run.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tb_top -f project.f --Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/tb_sim)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qxF "Everything OK" <<< "$sim_output"; then
    exit 0
fi
echo "Pass line not found in simulation output"
exit 1
